// ==== lu_consts.svh ====
// Load unit constants

`ifndef LU_CONSTS_SVH
`define LU_CONSTS_SVH

// ---------------------------------------------------------------------------
// data path and address widths
// ---------------------------------------------------------------------------

// width of the integer data path and of the cache read data
`define LU_XLEN 64

// virtual address width for Sv39
`define LU_VLEN 39

// physical address width as seen by the cache
`define LU_PLEN 56

// ---------------------------------------------------------------------------
// scoreboard and cache geometry
// ---------------------------------------------------------------------------

// transaction id handed out by the issue stage
`define LU_TRANS_ID_BITS 3

// byte offset inside one 64-bit word
`define LU_ALIGN_BITS 3

// the index fits inside the 4 KiB page offset, so it is known before translation
`define LU_DCACHE_INDEX_WIDTH 12
`define LU_DCACHE_TAG_WIDTH 44

`endif

// ==== lu_pkg.sv ====
// Load unit types

`default_nettype none

`include "lu_consts.svh"

package lu_pkg;

    // ---------------------------------------------------------------------------
    // load operations
    // ---------------------------------------------------------------------------

    // the U variants zero-extend, the others sign-extend (LD needs neither)
    typedef enum logic [2:0] {
        LD  = 3'd0,
        LW  = 3'd1,
        LWU = 3'd2,
        LH  = 3'd3,
        LHU = 3'd4,
        LB  = 3'd5,
        LBU = 3'd6
    } lu_op_e;

    // request as it comes out of the issue stage
    typedef struct packed {
        logic [`LU_VLEN-1:0]          vaddr;
        logic [`LU_TRANS_ID_BITS-1:0] trans_id;
        lu_op_e                       op;
        logic [7:0]                   be;
    } load_req_t;

    // exception record, valid is only meaningful together with the other fields
    typedef struct packed {
        logic                valid;
        logic [`LU_XLEN-1:0] cause;
        logic [`LU_XLEN-1:0] tval;
    } lu_exception_t;

    // ---------------------------------------------------------------------------
    // data cache port
    // ---------------------------------------------------------------------------

    // the index goes out with data_req, the tag follows one cycle later
    typedef struct packed {
        logic [`LU_DCACHE_INDEX_WIDTH-1:0] address_index;
        logic [`LU_DCACHE_TAG_WIDTH-1:0]   address_tag;
        logic                              data_req;
        logic [7:0]                        data_be;
        logic [1:0]                        data_size;
        logic                              kill_req;
        logic                              tag_valid;
    } dcache_req_t;

    // grant and return strobes from the cache
    typedef struct packed {
        logic                data_gnt;
        logic                data_rvalid;
        logic [`LU_XLEN-1:0] data_rdata;
    } dcache_rsp_t;

    // ---------------------------------------------------------------------------
    // internal traffic
    // ---------------------------------------------------------------------------

    // what the retire stage needs to know about the request state machine
    typedef struct packed {
        logic flushing;
        logic tag_cycle;
        logic waiting_translation;
        logic kill;
    } lu_fsm_status_t;

    // load that has been popped and now waits for its data
    // sign_idx and is_signed are prepared at capture time to keep the
    // return path short
    typedef struct packed {
        logic [`LU_TRANS_ID_BITS-1:0] trans_id;
        logic [`LU_ALIGN_BITS-1:0]    address_offset;
        lu_op_e                       op;
        logic [2:0]                   sign_idx;
        logic                         is_signed;
    } pending_load_t;

endpackage

`default_nettype wire

// ==== lu_load_fsm.sv ====
// Load request state machine

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module lu_load_fsm import lu_pkg::*; (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    input  wire logic           flush_i,
    input  wire logic           valid_i,
    input  wire load_req_t      load_req_i,
    input  wire logic           ex_valid_i,
    input  wire logic           dtlb_hit_i,
    input  wire logic           page_offset_matches_i,
    input  wire logic [`LU_PLEN-1:0] paddr_i,
    input  wire dcache_rsp_t    dcache_rsp_i,
    output dcache_req_t         dcache_req_o,
    output logic                translation_req_o,
    output logic                pop_ld_o,
    output lu_fsm_status_t      status_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_d;
    state_e state_q;

    logic data_req;
    logic kill_req;
    logic tag_valid;
    logic can_issue;

    // a new request is only taken when nothing is pending, or while the
    // previous one is sending its tag
    assign can_issue = (state_q == IDLE) || (state_q == SEND_TAG);

    // ---------------------------------------------------------------------------
    // next state and strobes
    // ---------------------------------------------------------------------------

    always_comb begin : p_next_state
        state_d           = state_q;
        data_req          = 1'b0;
        kill_req          = 1'b0;
        tag_valid         = 1'b0;
        translation_req_o = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            IDLE: begin
                // new requests are handled below together with SEND_TAG
                state_d = IDLE;
            end
            SEND_TAG: begin
                // the grant was taken last cycle so the tag is known to be good
                tag_valid = 1'b1;
                state_d   = IDLE;
                // an exception on the popped load means its data must never come back
                if (ex_valid_i) begin
                    kill_req = 1'b1;
                end
            end
            WAIT_PAGE_OFFSET: begin
                // an older store hits the same page offset, so hold off until it drains
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end
            ABORT_TRANSACTION: begin
                // TLB miss after the grant, release the cache with a killed tag
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = WAIT_TRANSLATION;
            end
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                // keep both requests up until the cache takes the index
                translation_req_o = 1'b1;
                data_req          = 1'b1;
            end
            WAIT_FLUSH: begin
                // kill whatever may still be outstanding in the cache
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // translation starts together with the index lookup, before the
        // page offset check is known, which keeps this path short
        if (can_issue && valid_i) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req = 1'b1;
                state_d  = WAIT_GNT;
            end
        end

        // a grant resolves the request both for a fresh issue and in WAIT_GNT
        if (data_req && dcache_rsp_i.data_gnt) begin
            if (dtlb_hit_i) begin
                state_d  = SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // the exception retires directly, unless data returns this cycle and
        // takes the result port. Then the load stays and is tried again
        if (ex_valid_i && valid_i) begin
            state_d = IDLE;
            if (!dcache_rsp_i.data_rvalid) begin
                pop_ld_o = 1'b1;
            end
        end

        // flush wins over everything, one extra cycle kills the request
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ---------------------------------------------------------------------------
    // cache port
    // ---------------------------------------------------------------------------

    // index from the untranslated page offset, tag from last cycle's translation
    assign dcache_req_o.address_index = load_req_i.vaddr[`LU_DCACHE_INDEX_WIDTH-1:0];
    assign dcache_req_o.address_tag   =
        paddr_i[`LU_DCACHE_TAG_WIDTH+`LU_DCACHE_INDEX_WIDTH-1:`LU_DCACHE_INDEX_WIDTH];
    assign dcache_req_o.data_req      = data_req;
    assign dcache_req_o.data_be       = load_req_i.be;
    assign dcache_req_o.kill_req      = kill_req;
    assign dcache_req_o.tag_valid     = tag_valid;

    // transfer size is log2 of the byte count
    always_comb begin : p_size
        case (load_req_i.op)
            LW, LWU: dcache_req_o.data_size = 2'b10;
            LH, LHU: dcache_req_o.data_size = 2'b01;
            LB, LBU: dcache_req_o.data_size = 2'b00;
            default: dcache_req_o.data_size = 2'b11;
        endcase
    end

    // status seen by the retire stage
    assign status_o.flushing            = (state_q == WAIT_FLUSH);
    assign status_o.tag_cycle           = (state_q == SEND_TAG);
    assign status_o.waiting_translation = (state_q == WAIT_TRANSLATION);
    assign status_o.kill                = kill_req;

endmodule

`default_nettype wire

// ==== lu_retire.sv ====
// Load retire stage

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module lu_retire import lu_pkg::*; (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,
    input  wire logic            valid_i,
    input  wire load_req_t       load_req_i,
    input  wire logic            pop_ld_i,
    input  wire logic            ex_valid_i,
    input  wire logic            rvalid_i,
    input  wire lu_fsm_status_t  status_i,
    output logic                 valid_o,
    output logic                 ex_valid_o,
    output logic [`LU_TRANS_ID_BITS-1:0] trans_id_o,
    output pending_load_t        pending_o
);

    pending_load_t pending_d;
    pending_load_t pending_q;

    // ---------------------------------------------------------------------------
    // pending load capture
    // ---------------------------------------------------------------------------

    // the sign byte sits at the top byte of the loaded field
    always_comb begin : p_capture
        pending_d.trans_id       = load_req_i.trans_id;
        pending_d.address_offset = load_req_i.vaddr[`LU_ALIGN_BITS-1:0];
        pending_d.op             = load_req_i.op;
        pending_d.is_signed      = load_req_i.op inside {LW, LH, LB};
        case (load_req_i.op)
            LW, LWU: pending_d.sign_idx = load_req_i.vaddr[2:0] + 3'd3;
            LH, LHU: pending_d.sign_idx = load_req_i.vaddr[2:0] + 3'd1;
            default: pending_d.sign_idx = load_req_i.vaddr[2:0];
        endcase
    end

    // an excepting pop leaves the register alone so an earlier load still
    // in flight keeps its id and offset
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
        if (!rst_ni) begin
            pending_q <= '0;
        end else if (pop_ld_i && !ex_valid_i) begin
            pending_q <= pending_d;
        end
    end

    assign pending_o = pending_q;

    // ---------------------------------------------------------------------------
    // retire decision
    // ---------------------------------------------------------------------------

    always_comb begin : p_retire
        valid_o    = 1'b0;
        ex_valid_o = 1'b0;
        trans_id_o = pending_q.trans_id;

        // returned data counts unless the request was flushed or killed
        if (rvalid_i && !status_i.flushing) begin
            if (!status_i.kill) begin
                valid_o = 1'b1;
            end
            // the exception of the popped load shows up in its tag cycle
            if (ex_valid_i && status_i.tag_cycle) begin
                valid_o    = 1'b1;
                ex_valid_o = 1'b1;
            end
        end

        // translation exceptions retire straight from the issue port,
        // normal data returns keep priority and the load is retried
        if (valid_i && ex_valid_i && !rvalid_i) begin
            valid_o    = 1'b1;
            ex_valid_o = 1'b1;
            trans_id_o = load_req_i.trans_id;
        end else if (status_i.waiting_translation) begin
            valid_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== lu_result_align.sv ====
// Load result aligner

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module lu_result_align import lu_pkg::*; (
    input  wire pending_load_t       pending_i,
    input  wire logic [`LU_XLEN-1:0] rdata_i,
    output logic [`LU_XLEN-1:0]      result_o
);

    logic [`LU_XLEN-1:0]   shifted;
    logic [`LU_XLEN/8-1:0] sign_bits;
    logic                  sign_bit;

    // bring the addressed byte down to bit 0
    assign shifted = rdata_i >> {pending_i.address_offset, 3'b000};

    // ---------------------------------------------------------------------------
    // sign bit selection
    // ---------------------------------------------------------------------------

    // top bit of every byte, picked by the precomputed index so this runs
    // in parallel with the shifter instead of after it
    for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_sign_bits
        assign sign_bits[i] = rdata_i[i*8+7];
    end

    // unsigned loads pull the fill bit to zero
    assign sign_bit = pending_i.is_signed & sign_bits[pending_i.sign_idx];

    // ---------------------------------------------------------------------------
    // result mux
    // ---------------------------------------------------------------------------

    always_comb begin : p_extend
        case (pending_i.op)
            LW, LWU: begin
                result_o = {{(`LU_XLEN-32){sign_bit}}, shifted[31:0]};
            end
            LH, LHU: begin
                result_o = {{(`LU_XLEN-16){sign_bit}}, shifted[15:0]};
            end
            LB, LBU: begin
                result_o = {{(`LU_XLEN-8){sign_bit}}, shifted[7:0]};
            end
            // LD is always aligned, so the shift is by zero
            default: begin
                result_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== load_unit.sv ====
// Load unit top level

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module load_unit import lu_pkg::*; (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic                    flush_i,
    // issue side
    input  wire logic                    valid_i,
    input  wire load_req_t               load_req_i,
    output logic                         pop_ld_o,
    // result side
    output logic                         valid_o,
    output logic [`LU_TRANS_ID_BITS-1:0] trans_id_o,
    output logic [`LU_XLEN-1:0]          result_o,
    output lu_exception_t                ex_o,
    // MMU
    output logic                         translation_req_o,
    output logic [`LU_VLEN-1:0]          vaddr_o,
    input  wire logic [`LU_PLEN-1:0]     paddr_i,
    input  wire lu_exception_t           ex_i,
    input  wire logic                    dtlb_hit_i,
    // address checker, which takes the page offset from vaddr_o
    input  wire logic                    page_offset_matches_i,
    // data cache
    input  wire dcache_rsp_t             dcache_rsp_i,
    output dcache_req_t                  dcache_req_o
);

    lu_fsm_status_t fsm_status;
    pending_load_t  pending;
    logic           ex_valid;

    // the MMU and the address checker both see the raw virtual address
    assign vaddr_o = load_req_i.vaddr;

    // cause and tval pass through, only the valid bit is decided here
    assign ex_o.valid = ex_valid;
    assign ex_o.cause = ex_i.cause;
    assign ex_o.tval  = ex_i.tval;

    lu_load_fsm u_load_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_req_i            (load_req_i),
        .ex_valid_i            (ex_i.valid),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .paddr_i               (paddr_i),
        .dcache_rsp_i          (dcache_rsp_i),
        .dcache_req_o          (dcache_req_o),
        .translation_req_o     (translation_req_o),
        .pop_ld_o              (pop_ld_o),
        .status_o              (fsm_status)
    );

    lu_retire u_retire (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .valid_i    (valid_i),
        .load_req_i (load_req_i),
        .pop_ld_i   (pop_ld_o),
        .ex_valid_i (ex_i.valid),
        .rvalid_i   (dcache_rsp_i.data_rvalid),
        .status_i   (fsm_status),
        .valid_o    (valid_o),
        .ex_valid_o (ex_valid),
        .trans_id_o (trans_id_o),
        .pending_o  (pending)
    );

    lu_result_align u_result_align (
        .pending_i (pending),
        .rdata_i   (dcache_rsp_i.data_rdata),
        .result_o  (result_o)
    );

endmodule

`default_nettype wire

// ==== lu_chk.sv ====
// Load unit protocol checker

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module lu_chk import lu_pkg::*; (
    input wire logic          clk_i,
    input wire logic          rst_ni,
    input wire logic          flush_i,
    input wire lu_exception_t ex_i,
    input wire logic          pop_ld_o,
    input wire logic          valid_o,
    input wire lu_exception_t ex_o,
    input wire dcache_req_t   dcache_req_o,
    input wire dcache_rsp_t   dcache_rsp_i,
    input wire pending_load_t pending_i
);

    // the tag follows a grant by one cycle, and an abort is itself the
    // cycle after a grant, so only grants and flushes can open a tag cycle
    a_tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.tag_valid |->
            $past(dcache_req_o.data_req && dcache_rsp_i.data_gnt) || $past(flush_i))
        else $error("tag_valid without a grant or flush in the previous cycle");

    // a load leaves the issue port only on a grant or as an exception
    a_pop_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> dcache_rsp_i.data_gnt || ex_i.valid)
        else $error("pop_ld_o without data_gnt or exception");

    // word loads are naturally aligned
    a_word_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !ex_o.valid && (pending_i.op == LW || pending_i.op == LWU))
            |-> pending_i.address_offset < 3'd5)
        else $error("word load retired with an offset above 4");

endmodule

bind load_unit lu_chk u_lu_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .ex_i         (ex_i),
    .pop_ld_o     (pop_ld_o),
    .valid_o      (valid_o),
    .ex_o         (ex_o),
    .dcache_req_o (dcache_req_o),
    .dcache_rsp_i (dcache_rsp_i),
    .pending_i    (pending)
);

`default_nettype wire

// ==== tb_load_unit.sv ====
// Load unit testbench

`timescale 1ns/1ns
`default_nettype none

`include "lu_consts.svh"

module tb_load_unit import lu_pkg::*; ();

    logic                         clk_i;
    logic                         rst_ni;
    logic                         flush_i;
    logic                         valid_i;
    load_req_t                    load_req_i;
    logic                         pop_ld_o;
    logic                         valid_o;
    logic [`LU_TRANS_ID_BITS-1:0] trans_id_o;
    logic [`LU_XLEN-1:0]          result_o;
    lu_exception_t                ex_o;
    logic                         translation_req_o;
    logic [`LU_VLEN-1:0]          vaddr_o;
    logic [`LU_PLEN-1:0]          paddr_i;
    lu_exception_t                ex_i;
    logic                         dtlb_hit_i;
    logic                         page_offset_matches_i;
    dcache_rsp_t                  dcache_rsp_i;
    dcache_req_t                  dcache_req_o;
    int                           seed;

    load_unit DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // reference model and compare tasks
    // ------------------------------------------------------------------------

    // expected load value, taken straight from the ISA rules
    function automatic logic [63:0] load_result(lu_op_e op, logic [2:0] offset,
                                                logic [63:0] data);
        logic [63:0] sh;
        sh = data >> (8 * offset);
        case (op)
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'd0, sh[31:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'd0, sh[15:0]};
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'd0, sh[7:0]};
            default: return data;
        endcase
    endfunction

    // what the cache port must show for a given request and phase
    function automatic dcache_req_t expected_req(load_req_t req, logic [55:0] paddr,
                                                 logic dreq, logic kill, logic tv);
        dcache_req_t r;
        r.address_index = req.vaddr[11:0];
        r.address_tag   = paddr[55:12];
        r.data_req      = dreq;
        r.data_be       = req.be;
        r.kill_req      = kill;
        r.tag_valid     = tv;
        case (req.op)
            LW, LWU: r.data_size = 2'd2;
            LH, LHU: r.data_size = 2'd1;
            LB, LBU: r.data_size = 2'd0;
            default: r.data_size = 2'd3;
        endcase
        return r;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error result_o got %h expected %h", got, exp));
    endtask

    task automatic check_trans_id(logic [2:0] got, logic [2:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error trans_id_o got %h expected %h", got, exp));
    endtask

    task automatic check_exception(lu_exception_t got, lu_exception_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Error ex_o got %h expected %h", got, exp));
    endtask

    task automatic check_dcache_req(dcache_req_t got, dcache_req_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Error dcache_req_o got %h expected %h", got, exp));
    endtask

    task automatic check_vaddr(logic [`LU_VLEN-1:0] got, logic [`LU_VLEN-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Error vaddr_o got %h expected %h", got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Error %s got %h expected %h", name, got, exp));
    endtask

    // the MMU sees the virtual address of the request at the issue port
    task automatic check_mmu_req(load_req_t req, logic exp_req);
        check_bit("translation_req_o", translation_req_o, exp_req);
        check_vaddr(vaddr_o, req.vaddr);
    endtask

    // ------------------------------------------------------------------------
    // cache and MMU sequences
    // ------------------------------------------------------------------------

    task automatic wait_data_req();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!dcache_req_o.data_req) begin
            n++;
            if (n > 20) stop_on_error("data_req never rose for a pending load");
            @(negedge clk_i);
        end
    endtask

    // holds the grant back, then grants with the given TLB result
    task automatic grant(load_req_t req, logic [55:0] paddr, int delay, logic hit);
        wait_data_req();
        repeat (delay) begin
            check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b1, 1'b0, 1'b0));
            check_mmu_req(req, 1'b1);
            @(negedge clk_i);
        end
        @(posedge clk_i);
        dcache_rsp_i.data_gnt <= 1'b1;
        dtlb_hit_i            <= hit;
        @(negedge clk_i);
        check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b1, 1'b0, 1'b0));
        check_mmu_req(req, 1'b1);
        check_bit("pop_ld_o", pop_ld_o, hit);
        @(posedge clk_i);
        dcache_rsp_i.data_gnt <= 1'b0;
        dtlb_hit_i            <= 1'b1;
        if (hit) valid_i <= 1'b0;
    endtask

    task automatic run_load(load_req_t req, logic [63:0] data, int delay,
                            logic miss, int match_cycles, logic flush);
        logic [63:0] tmp;
        logic [55:0] paddr;
        int          ret;
        tmp   = {$random(seed), $random(seed)};
        paddr = tmp[55:0];
        ret   = $random(seed) & 3;
        @(posedge clk_i);
        valid_i                 <= 1'b1;
        load_req_i              <= req;
        paddr_i                 <= paddr;
        page_offset_matches_i   <= (match_cycles > 0);
        dcache_rsp_i.data_rdata <= data;
        // an older store blocks the cache request
        if (match_cycles > 0) begin
            repeat (match_cycles) begin
                @(negedge clk_i);
                check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b0, 1'b0, 1'b0));
            end
            @(posedge clk_i);
            page_offset_matches_i <= 1'b0;
        end
        if (miss) begin
            grant(req, paddr, delay, 1'b0);
            @(negedge clk_i);
            check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b0, 1'b1, 1'b1));
            check_bit("valid_o", valid_o, 1'b0);
            // translation takes two more cycles
            @(posedge clk_i);
            dtlb_hit_i <= 1'b0;
            repeat (2) begin
                @(negedge clk_i);
                check_mmu_req(req, 1'b1);
                @(posedge clk_i);
            end
            dtlb_hit_i <= 1'b1;
        end
        grant(req, paddr, delay, 1'b1);
        if (flush) begin
            flush_i <= 1'b1;
            @(negedge clk_i);
            check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b0, 1'b0, 1'b1));
            @(posedge clk_i);
            flush_i                  <= 1'b0;
            dcache_rsp_i.data_rvalid <= 1'b1;
            @(negedge clk_i);
            check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b0, 1'b1, 1'b1));
            check_bit("valid_o", valid_o, 1'b0);
        end else begin
            if (ret == 0) dcache_rsp_i.data_rvalid <= 1'b1;
            @(negedge clk_i);
            check_dcache_req(dcache_req_o, expected_req(req, paddr, 1'b0, 1'b0, 1'b1));
            check_mmu_req(req, 1'b0);
            for (int i = 1; i <= ret; i++) begin
                check_bit("valid_o", valid_o, 1'b0);
                @(posedge clk_i);
                if (i == ret) dcache_rsp_i.data_rvalid <= 1'b1;
                @(negedge clk_i);
            end
            check_bit("valid_o", valid_o, 1'b1);
            check_bit("ex_o.valid", ex_o.valid, 1'b0);
            check_result(result_o, load_result(req.op, req.vaddr[2:0], data));
            check_trans_id(trans_id_o, req.trans_id);
        end
        @(posedge clk_i);
        dcache_rsp_i.data_rvalid <= 1'b0;
    endtask

    task automatic run_exception(load_req_t req, lu_exception_t ex);
        lu_exception_t none;
        none = '0;
        @(posedge clk_i);
        valid_i    <= 1'b1;
        load_req_i <= req;
        ex_i       <= ex;
        @(negedge clk_i);
        check_bit("valid_o", valid_o, 1'b1);
        check_bit("pop_ld_o", pop_ld_o, 1'b1);
        check_mmu_req(req, 1'b1);
        check_exception(ex_o, ex);
        check_trans_id(trans_id_o, req.trans_id);
        @(posedge clk_i);
        valid_i <= 1'b0;
        ex_i    <= none;
    endtask

    // random request with a naturally aligned offset for its size
    function automatic load_req_t make_req(int op_sel, int id);
        load_req_t   r;
        logic [63:0] tmp;
        logic [2:0]  off;
        tmp = {$random(seed), $random(seed)};
        r.op = lu_op_e'(op_sel[2:0]);
        case (r.op)
            LW, LWU: off = {tmp[40], 2'b00};
            LH, LHU: off = {tmp[41:40], 1'b0};
            LB, LBU: off = tmp[42:40];
            default: off = 3'd0;
        endcase
        r.vaddr    = {tmp[35:0], off};
        r.trans_id = id[2:0];
        r.be       = tmp[55:48];
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        lu_exception_t ex;
        seed                  = 32'hadde_f93d;
        rst_ni                <= 1'b0;
        flush_i               <= 1'b0;
        valid_i               <= 1'b0;
        load_req_i            <= '0;
        paddr_i               <= '0;
        ex_i                  <= '0;
        dtlb_hit_i            <= 1'b1;
        page_offset_matches_i <= 1'b0;
        dcache_rsp_i          <= '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int i = 0; i < 35; i++)
            run_load(make_req(i % 7, i), {$random(seed), $random(seed)},
                     $random(seed) & 3, 1'b0, 0, 1'b0);
        for (int i = 0; i < 7; i++)
            run_load(make_req(i, i), {$random(seed), $random(seed)}, 1, 1'b1, 0, 1'b0);
        for (int i = 0; i < 7; i++)
            run_load(make_req(i, i + 1), {$random(seed), $random(seed)}, 0, 1'b0,
                     1 + (i % 3), 1'b0);
        for (int i = 0; i < 4; i++) begin
            ex.valid = 1'b1;
            ex.cause = {$random(seed), $random(seed)};
            ex.tval  = {$random(seed), $random(seed)};
            run_exception(make_req(i, i + 3), ex);
        end
        for (int i = 0; i < 3; i++)
            run_load(make_req(i, i), {$random(seed), $random(seed)}, i, 1'b0, 0, 1'b1);
        run_load(make_req(1, 5), {$random(seed), $random(seed)}, 2, 1'b0, 0, 1'b0);
        repeat (2) @(posedge clk_i);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
lu_pkg.sv
lu_load_fsm.sv
lu_retire.sv
lu_result_align.sv
load_unit.sv
lu_chk.sv
tb_load_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load unit simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f sources.f --top-module tb_load_unit -o sim_load_unit
output=$(./obj_dir/sim_load_unit 2>&1 || true)
echo "$output"
echo "$output" | grep -q "Test passed"
